// ==== Bender.yml ====
package:
  name: board_top

sources:
  - board_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - disp_format.sv
  - seg_scan.sv
  - key_debounce.sv
  - beeper.sv
  - board_top.sv
  - target: test
    files:
      - tb_board_checker.sv
      - tb_board_top.sv

// ==== all.f ====
board_pkg.sv
uart_rx.sv
uart_tx.sv
disp_format.sv
seg_scan.sv
key_debounce.sv
beeper.sv
board_top.sv
tb_board_checker.sv
tb_board_top.sv

// ==== beeper.sv ====
//******************************
// buzzer burst of BEEP_CYCLES clocks after a key press
//******************************
module beeper (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_press,
	output logic       buzzer
);

	import board_pkg::*;

	logic [BEEP_CNT_W-1:0] beep_cnt;

	// a new press reloads and so restarts the burst
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			beep_cnt <= '0;
		end else if (|key_press) begin
			beep_cnt <= BEEP_CNT_W'(BEEP_CYCLES);
		end else if (beep_cnt != '0) begin
			beep_cnt <= beep_cnt - 1'b1;
		end
	end

	assign buzzer = (beep_cnt != '0);

endmodule

// ==== board_golden.txt ====
# B byte count : send a uart byte, expected display count in hex
# F byte : frame with a low stop bit ; K key led : press key, expected led[3:0] in hex
B 41 01
B a5 02
K 0 1
B 3c 03
F 77
K 2 5
B ff 04
K 0 4
F 00
B 00 05
K 3 c
K 1 e
B 7e 06
F c3
K 2 a
B 5a 07
K 3 2
B 81 08

// ==== board_pkg.sv ====
//******************************
// shared timing constants, digit codes and the segment font
// all timing is at simulation scale, a board build edits only this package
//******************************
package board_pkg;

	// uart, debounce, scan and buzzer timing in sys_clk cycles
	localparam int CLKS_PER_BIT    = 16;
	localparam int DEBOUNCE_CYCLES = 64;
	localparam int SCAN_CYCLES     = 8;
	localparam int BEEP_CYCLES     = 200;

	localparam int NUM_DIGITS = 8;
	localparam int NUM_KEYS   = 4;

	// counter widths derived from the timing values
	localparam int BIT_CNT_W  = $clog2(CLKS_PER_BIT);
	localparam int DEB_CNT_W  = $clog2(DEBOUNCE_CYCLES);
	localparam int SCAN_CNT_W = $clog2(SCAN_CYCLES);
	localparam int BEEP_CNT_W = $clog2(BEEP_CYCLES + 1);

	// 0..15 are hex digits
	typedef logic [4:0] digit_code_t;

	localparam digit_code_t DIGIT_BLANK = 5'd16;
	localparam digit_code_t DIGIT_DASH  = 5'd17;

	// active low pattern, a in bit 0 up to g in bit 6, dp in bit 7 kept off
	function automatic logic [7:0] seg_font(input digit_code_t code);
		logic [6:0] lit;
		case (code)
			5'd0:       lit = 7'h3f;
			5'd1:       lit = 7'h06;
			5'd2:       lit = 7'h5b;
			5'd3:       lit = 7'h4f;
			5'd4:       lit = 7'h66;
			5'd5:       lit = 7'h6d;
			5'd6:       lit = 7'h7d;
			5'd7:       lit = 7'h07;
			5'd8:       lit = 7'h7f;
			5'd9:       lit = 7'h6f;
			5'd10:      lit = 7'h77;
			5'd11:      lit = 7'h7c;
			5'd12:      lit = 7'h39;
			5'd13:      lit = 7'h5e;
			5'd14:      lit = 7'h79;
			5'd15:      lit = 7'h71;
			DIGIT_DASH: lit = 7'h40;
			default:    lit = 7'h00;
		endcase
		return {1'b1, ~lit};
	endfunction

endpackage

// ==== board_top.sv ====
//******************************
// trainer board top, uart echo with byte display
// plus debounced keys driving leds and the buzzer
//******************************
module board_top (
	input  logic       sys_clk,
	input  logic       sys_rst_n,

	input  logic [3:0] key_in,
	output logic       buzzer,
	output logic [7:0] led,

	// seven-segment display
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice,

	// uart to the microcontroller
	input  logic       uart_rx_port,
	output logic       uart_tx_port
);

	logic [7:0]  rx_byte;
	logic        rx_valid;
	logic [39:0] digit_codes;
	logic [3:0]  key_press;

	uart_rx i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_pin    (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	// echo, a byte arriving mid-transmission is dropped inside uart_tx
	uart_tx i_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_start  (rx_valid),
		.tx_byte   (rx_byte),
		.tx_pin    (uart_tx_port),
		.tx_busy   ()
	);

	disp_format i_disp_format (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.digit_codes (digit_codes)
	);

	seg_scan i_seg_scan (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.digit_codes (digit_codes),
		.seg_number  (seg_number),
		.seg_choice  (seg_choice)
	);

	key_debounce i_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_press (key_press),
		.led       (led)
	);

	beeper i_beeper (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_press (key_press),
		.buzzer    (buzzer)
	);

endmodule

// ==== disp_format.sv ====
//******************************
// keeps the last received byte and a byte count
// and lays them out as eight digit codes for the scanner
//******************************
module disp_format (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [7:0]  rx_byte,
	input  logic        rx_valid,
	output logic [39:0] digit_codes
);

	import board_pkg::*;

	logic [7:0]  last_byte;
	logic        seen;
	logic [7:0]  byte_cnt;
	digit_code_t byte_hi;
	digit_code_t byte_lo;
	digit_code_t cnt_hi;
	digit_code_t cnt_lo;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seen     <= 1'b0;
			byte_cnt <= '0;
		end else if (rx_valid) begin
			seen     <= 1'b1;
			// wraps after 255
			byte_cnt <= byte_cnt + 8'd1;
		end
	end

	// only shown once seen is set
	always_ff @(posedge sys_clk) begin
		if (rx_valid)
			last_byte <= rx_byte;
	end

	always_comb begin
		cnt_hi  = {1'b0, byte_cnt[7:4]};
		cnt_lo  = {1'b0, byte_cnt[3:0]};
		byte_hi = seen ? {1'b0, last_byte[7:4]} : DIGIT_BLANK;
		byte_lo = seen ? {1'b0, last_byte[3:0]} : DIGIT_BLANK;
	end

	// digit 7 first, a fixed F marks the left end
	assign digit_codes = {
		5'd15, DIGIT_BLANK, DIGIT_DASH, cnt_hi,
		cnt_lo, DIGIT_BLANK, byte_hi, byte_lo
	};

endmodule

// ==== key_debounce.sv ====
//******************************
// debounces the four keys, keys are low when pressed
// led[3:0] toggle per press, led[7:4] follow the held keys
//******************************
module key_debounce (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	output logic [3:0] key_press,
	output logic [7:0] led
);

	import board_pkg::*;

	logic [NUM_KEYS-1:0]  key_meta;
	logic [NUM_KEYS-1:0]  key_sync;
	logic [NUM_KEYS-1:0]  key_level;
	logic [DEB_CNT_W-1:0] stable_cnt [NUM_KEYS];
	logic [3:0]           led_toggle;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta  <= '1;
			key_sync  <= '1;
			key_level <= '1;
			key_press <= '0;
			for (int i = 0; i < NUM_KEYS; i++)
				stable_cnt[i] <= '0;
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
			for (int i = 0; i < NUM_KEYS; i++) begin
				key_press[i] <= 1'b0;
				// any bounce back to the accepted level restarts the count
				if (key_sync[i] == key_level[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
					stable_cnt[i] <= '0;
					key_level[i]  <= key_sync[i];
					key_press[i]  <= key_level[i];
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			led_toggle <= '0;
		else
			led_toggle <= led_toggle ^ key_press;
	end

	assign led = {~key_level, led_toggle};

endmodule

// ==== seg_scan.sv ====
//******************************
// multiplexes eight digit codes onto one segment bus
// one digit every SCAN_CYCLES clocks, select is active low
//******************************
module seg_scan (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [39:0] digit_codes,
	output logic [7:0]  seg_number,
	output logic [7:0]  seg_choice
);

	import board_pkg::*;

	logic [SCAN_CNT_W-1:0] prescale;
	logic                  step;
	logic [2:0]            digit_idx;
	digit_code_t           cur_code;

	assign step = (prescale == SCAN_CNT_W'(SCAN_CYCLES - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			prescale <= '0;
		end else if (step) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// code of the digit to be lit at the next step
	always_comb begin
		cur_code = digit_codes[digit_idx*5 +: 5];
	end

	// number and select latch together so no ghosting between digits
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			digit_idx  <= '0;
			seg_number <= 8'hff;
			seg_choice <= 8'hff;
		end else if (step) begin
			seg_number <= seg_font(cur_code);
			seg_choice <= ~(8'b1 << digit_idx);
			// wraps from 7 back to 0
			digit_idx  <= digit_idx + 3'd1;
		end
	end

endmodule

// ==== tb_board_checker.sv ====
//******************************
// watches the board pins and compares them with expected values
// the testbench starts each check with check_strobe and waits on check_busy
//******************************
module tb_board_checker (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	input  logic       buzzer,
	input  logic [7:0] led,
	input  logic [7:0] seg_number,
	input  logic [7:0] seg_choice,
	input  logic       uart_tx_port,
	input  logic       check_strobe,
	input  logic [7:0] check_op,
	input  logic [7:0] exp_byte,
	input  logic [7:0] exp_count,
	input  logic       exp_seen,
	input  logic [3:0] exp_led,
	input  logic [3:0] exp_held,
	output logic       check_busy,
	output int         mismatch_count,
	output int         other_count
);

	import board_pkg::*;

	logic [7:0] echo_q[$];
	logic       burst_seen;
	logic [3:0] key_prev;
	logic       buzz_prev;
	int         cyc;
	int         last_fall;
	int         high_len;

	initial begin
		mismatch_count = 0;
		other_count    = 0;
		check_busy     = 1'b0;
		burst_seen     = 1'b0;
		cyc            = 0;
		last_fall      = 0;
		high_len       = 0;
	end

	// display layout with digit 7 on the left
	function automatic digit_code_t expected_code(input int d);
		case (d)
			7:       return 5'd15;
			6:       return DIGIT_BLANK;
			5:       return DIGIT_DASH;
			4:       return {1'b0, exp_count[7:4]};
			3:       return {1'b0, exp_count[3:0]};
			2:       return DIGIT_BLANK;
			1:       return exp_seen ? {1'b0, exp_byte[7:4]} : DIGIT_BLANK;
			default: return exp_seen ? {1'b0, exp_byte[3:0]} : DIGIT_BLANK;
		endcase
	endfunction

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			mismatch_count++;
		end
	endtask

	// echo deserializer sampling near the middle of each bit
	always begin : echo_rx
		logic [7:0] data;
		@(negedge sys_clk);
		if (sys_rst_n && !uart_tx_port) begin
			repeat (CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);
			if (uart_tx_port) begin
				$display("echo start bit did not stay low");
				other_count++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				data[i] = uart_tx_port;
			end
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
			if (!uart_tx_port) begin
				$display("echo stop bit was low");
				other_count++;
			end
			echo_q.push_back(data);
		end
	end

	// buzzer burst timing against the last key edge
	always @(negedge sys_clk) begin
		cyc++;
		if (!sys_rst_n) begin
			key_prev  = 4'hf;
			buzz_prev = 1'b0;
			high_len  = 0;
		end else begin
			if ((key_prev & ~key_in) != 4'h0)
				last_fall = cyc;
			if (buzzer && !buzz_prev && cyc - last_fall > DEBOUNCE_CYCLES + 8) begin
				$display("buzzer started too late after a key press");
				other_count++;
			end
			if (buzzer) begin
				high_len++;
			end else if (buzz_prev) begin
				compare("buzzer burst length", 8'(high_len), 8'(BEEP_CYCLES));
				burst_seen = 1'b1;
				high_len   = 0;
			end
			key_prev  = key_in;
			buzz_prev = buzzer;
		end
	end

	task automatic check_display();
		logic [7:0] seen_seg [8];
		logic [7:0] got_mask;
		int         waited;
		got_mask = '0;
		waited   = 0;
		while (got_mask != 8'hff && waited < 2 * SCAN_CYCLES * NUM_DIGITS) begin
			for (int d = 0; d < NUM_DIGITS; d++) begin
				if (seg_choice == ~(8'b1 << d)) begin
					seen_seg[d] = seg_number;
					got_mask[d] = 1'b1;
				end
			end
			@(negedge sys_clk);
			waited++;
		end
		if (got_mask != 8'hff) begin
			$display("display scan did not select all eight digits");
			other_count++;
		end else begin
			for (int d = 0; d < NUM_DIGITS; d++)
				compare($sformatf("seg_number digit %0d", d), seen_seg[d],
				        seg_font(expected_code(d)));
		end
	endtask

	task automatic run_check();
		@(negedge sys_clk);
		case (check_op)
			"R": begin
				compare("seg_choice", seg_choice, 8'hff);
				compare("led", led, 8'h00);
				compare("buzzer", {7'b0, buzzer}, 8'h00);
				compare("uart_tx_port", {7'b0, uart_tx_port}, 8'h01);
			end
			"B": begin
				if (echo_q.size() != 1) begin
					$display("expected one echoed byte, saw %0d", echo_q.size());
					other_count++;
				end else begin
					compare("uart_tx_port echo", echo_q[0], exp_byte);
				end
				echo_q.delete();
				check_display();
			end
			"F": begin
				if (echo_q.size() != 0) begin
					$display("a frame with a bad stop bit was echoed");
					other_count++;
				end
				echo_q.delete();
				check_display();
			end
			"H": begin
				compare("led[7:4]", {4'h0, led[7:4]}, {4'h0, exp_held});
			end
			"K": begin
				compare("led[3:0]", {4'h0, led[3:0]}, {4'h0, exp_led});
				compare("led[7:4]", {4'h0, led[7:4]}, 8'h00);
				compare("buzzer", {7'b0, buzzer}, 8'h00);
				if (!burst_seen) begin
					$display("no buzzer burst after the key press");
					other_count++;
				end
				burst_seen = 1'b0;
			end
			default: begin
				$display("checker got an unknown operation");
				other_count++;
			end
		endcase
		@(posedge sys_clk);
	endtask

	always @(posedge sys_clk) begin
		if (check_strobe && !check_busy) begin
			check_busy = 1'b1;
			run_check();
			check_busy = 1'b0;
		end
	end

endmodule

// ==== tb_board_top.sv ====
//******************************
// testbench for the trainer board top
// runs the operations listed in board_golden.txt against the DUT
//******************************
module tb_board_top;

	import board_pkg::*;

	// two uart frames, a beep and the debounce waits
	localparam int LONGEST_OP = 2 * 10 * CLKS_PER_BIT + BEEP_CYCLES + 4 * DEBOUNCE_CYCLES;

	logic       sys_clk;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic       buzzer;
	logic [7:0] led;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;
	logic       uart_rx_port;
	logic       uart_tx_port;

	logic       check_strobe;
	logic [7:0] check_op;
	logic [7:0] exp_byte;
	logic [7:0] exp_count;
	logic       exp_seen;
	logic [3:0] exp_led;
	logic [3:0] exp_held;
	logic       check_busy;
	int         mismatch_count;
	int         other_count;

	integer     seed;
	int         cycle_count;
	int         timeout_limit;
	byte        op_list[$];
	logic [7:0] arg1_list[$];
	logic [7:0] arg2_list[$];
	logic       golden_ok;

	board_top i_board_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.buzzer       (buzzer),
		.led          (led),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	tb_board_checker tb_board_checker (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.key_in         (key_in),
		.buzzer         (buzzer),
		.led            (led),
		.seg_number     (seg_number),
		.seg_choice     (seg_choice),
		.uart_tx_port   (uart_tx_port),
		.check_strobe   (check_strobe),
		.check_op       (check_op),
		.exp_byte       (exp_byte),
		.exp_count      (exp_count),
		.exp_seen       (exp_seen),
		.exp_led        (exp_led),
		.exp_held       (exp_held),
		.check_busy     (check_busy),
		.mismatch_count (mismatch_count),
		.other_count    (other_count)
	);

	always #5 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic int pick_delay(input int lo, input int hi);
		int r;
		r = $random(seed);
		if (r < 0)
			r = -r;
		return lo + (r % (hi - lo + 1));
	endfunction

	task automatic load_golden(output logic ok);
		int         fd;
		int         n;
		string      line;
		byte        op;
		logic [7:0] v1;
		logic [7:0] v2;
		ok = 1'b0;
		fd = $fopen("board_golden.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				if ($fgets(line, fd) == 0)
					break;
				v2 = '0;
				n = $sscanf(line, "%c %h %h", op, v1, v2);
				// comment lines start with #
				if (n >= 2 && op != "#") begin
					op_list.push_back(op);
					arg1_list.push_back(v1);
					arg2_list.push_back(v2);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		uart_rx_port = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_port = data[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		uart_rx_port = stop_bit;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		uart_rx_port = 1'b1;
	endtask

	task automatic request_check(input byte op);
		check_op     = op;
		check_strobe = 1'b1;
		@(negedge sys_clk);
		check_strobe = 1'b0;
		while (check_busy)
			@(negedge sys_clk);
	endtask

	// short random bounce on both edges of the press
	task automatic press_key(input int idx);
		int glitches;
		glitches = pick_delay(1, 3);
		for (int g = 0; g < glitches; g++) begin
			key_in[idx] = 1'b0;
			repeat (pick_delay(1, 10)) @(negedge sys_clk);
			key_in[idx] = 1'b1;
			repeat (pick_delay(1, 10)) @(negedge sys_clk);
		end
		key_in[idx] = 1'b0;
		repeat (DEBOUNCE_CYCLES + 40) @(negedge sys_clk);
		// held key shows on the upper leds
		exp_held = 4'b0001 << idx;
		request_check("H");
		for (int g = 0; g < glitches; g++) begin
			key_in[idx] = 1'b1;
			repeat (pick_delay(1, 10)) @(negedge sys_clk);
			key_in[idx] = 1'b0;
			repeat (pick_delay(1, 10)) @(negedge sys_clk);
		end
		key_in[idx] = 1'b1;
		repeat (DEBOUNCE_CYCLES + BEEP_CYCLES + 40) @(negedge sys_clk);
	endtask

	task automatic run_ops();
		for (int i = 0; i < op_list.size(); i++) begin
			case (op_list[i])
				"B": begin
					send_frame(arg1_list[i], 1'b1);
					// room for the whole echo frame
					repeat (2 * 10 * CLKS_PER_BIT + 20) @(negedge sys_clk);
					exp_byte  = arg1_list[i];
					exp_count = arg2_list[i];
					exp_seen  = 1'b1;
					request_check("B");
				end
				"F": begin
					send_frame(arg1_list[i], 1'b0);
					repeat (2 * 10 * CLKS_PER_BIT + 20) @(negedge sys_clk);
					request_check("F");
				end
				"K": begin
					press_key(arg1_list[i][1:0]);
					exp_led = arg2_list[i][3:0];
					request_check("K");
				end
				default: request_check(op_list[i]);
			endcase
			repeat (pick_delay(0, 31)) @(negedge sys_clk);
		end
	endtask

	initial begin
		seed          = 32'h87ea;
		sys_clk       = 1'b0;
		sys_rst_n     = 1'b0;
		key_in        = 4'hf;
		uart_rx_port  = 1'b1;
		check_strobe  = 1'b0;
		check_op      = '0;
		exp_byte      = '0;
		exp_count     = '0;
		exp_seen      = 1'b0;
		exp_led       = '0;
		exp_held      = '0;
		cycle_count   = 0;
		timeout_limit = 1000;
		load_golden(golden_ok);
		if (!golden_ok) begin
			$display("could not open board_golden.txt");
			$display("TEST FAILED");
			$finish;
		end else begin
			timeout_limit = op_list.size() * LONGEST_OP + 2000;
			repeat (4) @(negedge sys_clk);
			sys_rst_n = 1'b1;
			request_check("R");
			run_ops();
			$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
			if (mismatch_count == 0 && other_count == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

// ==== uart_rx.sv ====
//******************************
// uart receiver, 8n1, oversampled at CLKS_PER_BIT
// pulses rx_valid for one cycle at the middle of a good stop bit
//******************************
module uart_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx_pin,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	import board_pkg::*;

	logic                 rx_meta;
	logic                 rx_sync;
	logic                 active;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [3:0]           bit_idx;
	logic [BIT_CNT_W-1:0] sample_at;
	logic [7:0]           rx_shift;

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_pin;
			rx_sync <= rx_meta;
		end
	end

	// half a bit to the start bit middle, whole bits afterwards
	assign sample_at = (bit_idx == 4'd0) ? BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)
	                                     : BIT_CNT_W'(CLKS_PER_BIT - 1);

	// bit_idx 0 is the start bit, 1..8 data, 9 stop
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active   <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!active) begin
				clk_cnt <= '0;
				bit_idx <= '0;
				if (!rx_sync)
					active <= 1'b1;
			end else if (clk_cnt == sample_at) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd0) begin
					// glitch rather than a real start bit
					if (rx_sync)
						active <= 1'b0;
					else
						bit_idx <= 4'd1;
				end else if (bit_idx == 4'd9) begin
					active   <= 1'b0;
					rx_valid <= rx_sync;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (active && clk_cnt == sample_at && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			rx_shift <= {rx_sync, rx_shift[7:1]};
	end

	assign rx_byte = rx_shift;

endmodule

// ==== uart_tx.sv ====
//******************************
// uart transmitter, 8n1 at CLKS_PER_BIT
// a start while busy is ignored
//******************************
module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_pin,
	output logic       tx_busy
);

	import board_pkg::*;

	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [3:0]           bit_idx;
	logic                 accept;
	// data bits then the stop bit, start bit goes out directly
	logic [8:0]           frame;

	assign accept = tx_start && !tx_busy;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_pin  <= 1'b1;
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (accept) begin
			// start bit from the next cycle
			tx_pin  <= 1'b0;
			tx_busy <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (tx_busy) begin
			if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin
					// end of stop bit, line already high
					tx_busy <= 1'b0;
					tx_pin  <= 1'b1;
				end else begin
					tx_pin  <= frame[0];
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			frame <= {1'b1, tx_byte};
		else if (tx_busy && clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1))
			frame <= {1'b1, frame[8:1]};
	end

endmodule
